// ==== iic_pkg.sv ====
package iic_pkg;

    ////////////////////////////////////////
    // Bus timing
    ////////////////////////////////////////
    localparam int CLK_KHZ    = 100000;              // System clock
    localparam int SCL_KHZ    = 100;                 // Standard mode
    localparam int SCL_PERIOD = CLK_KHZ / SCL_KHZ;   // Clocks per SCL period

    // Phase points inside one period
    localparam int PH_HIGH_START = 0;
    localparam int PH_HIGH_MID   = SCL_PERIOD / 4;
    localparam int PH_LOW_START  = SCL_PERIOD / 2;
    localparam int PH_LOW_MID    = (3 * SCL_PERIOD) / 4;

    localparam int CNT_W  = $clog2(SCL_PERIOD);
    localparam int BYTE_W = 8;

    ////////////////////////////////////////
    // Command and bus operations
    ////////////////////////////////////////
    typedef struct packed {
        logic              rd;           // 1 for register read
        logic [6:0]        slave_addr;
        logic [BYTE_W-1:0] reg_addr;
        logic [BYTE_W-1:0] wdata;        // Ignored on reads
    } iic_cmd_t;

    typedef enum logic [2:0] {
        OP_START,
        OP_RESTART,
        OP_WRITE,
        OP_READ_NACK,    // Eight bits in, then master NACK
        OP_ACK_SLOT,
        OP_STOP
    } iic_op_e;

endpackage

// ==== iic_phase_if.sv ====
interface iic_phase_if;

    // One-cycle strobes at the four phase points
    logic hs;    // SCL high start
    logic hc;    // SCL high middle
    logic ls;    // SCL low start
    logic lc;    // SCL low middle

    modport source (
        output hs, hc, ls, lc
    );

    modport sink (
        input hs, hc, ls, lc
    );

endinterface

// ==== iic_byte_if.sv ====
interface iic_byte_if;

    logic                        op_valid;   // Held until op_done
    iic_pkg::iic_op_e            op;
    logic [iic_pkg::BYTE_W-1:0]  wr_byte;
    logic                        op_done;    // Pulse on the closing ls
    logic [iic_pkg::BYTE_W-1:0]  rd_byte;    // Kept until the next read

    // Sequencer side
    modport client (
        output op_valid, op, wr_byte,
        input  op_done, rd_byte
    );

    // Shifter side
    modport server (
        input  op_valid, op, wr_byte,
        output op_done, rd_byte
    );

endinterface

// ==== iic_stage_buf.sv ====
module iic_stage_buf #(
    parameter type T = logic [7:0]
) (
    input  logic i_clk,
    input  logic i_rst,
    // Upstream side
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    // Downstream side
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic full;
    T     data_q;

    assign o_ready = !full;    // No pass-through while draining
    assign o_valid = full;
    assign o_data  = data_q;

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            full <= 1'b0;
        end else if (i_valid && o_ready) begin
            full <= 1'b1;
        end else if (o_valid && i_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            data_q <= i_data;
        end
    end

    // Offered entry waits unchanged until taken
    assert property (@(posedge i_clk) disable iff (!i_rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

// ==== iic_scl_timer.sv ====
module iic_scl_timer (
    input  logic        i_clk,
    input  logic        i_rst,
    output logic        o_scl,
    iic_phase_if.source o_ph
);

    typedef logic [iic_pkg::CNT_W-1:0] cnt_t;

    cnt_t       cnt;
    logic       wrap;
    logic [3:0] strb;

    assign wrap = (cnt == cnt_t'(iic_pkg::SCL_PERIOD - 1));

    // Phase compares
    assign strb[3] = (cnt == cnt_t'(iic_pkg::PH_HIGH_START));
    assign strb[2] = (cnt == cnt_t'(iic_pkg::PH_HIGH_MID));
    assign strb[1] = (cnt == cnt_t'(iic_pkg::PH_LOW_START));
    assign strb[0] = (cnt == cnt_t'(iic_pkg::PH_LOW_MID));

    assign o_ph.hs = strb[3];
    assign o_ph.hc = strb[2];
    assign o_ph.ls = strb[1];
    assign o_ph.lc = strb[0];

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            cnt   <= '0;
            o_scl <= 1'b1;    // Idle bus
        end else begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            if (wrap) begin
                o_scl <= 1'b1;    // High from PH_HIGH_START
            end else if (cnt == cnt_t'(iic_pkg::PH_LOW_START - 1)) begin
                o_scl <= 1'b0;
            end
        end
    end

    // One strobe every quarter period, never two at once
    assert property (@(posedge i_clk) disable iff (!i_rst)
        $onehot(strb) |=>
            (strb == '0) [* iic_pkg::SCL_PERIOD / 4 - 1] ##1 $onehot(strb));

endmodule

// ==== iic_byte_shifter.sv ====
module iic_byte_shifter (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_sda,
    output logic        o_sda,
    output logic        o_sda_oe,
    iic_phase_if.sink   i_ph,
    iic_byte_if.server  i_op
);

    typedef logic [$clog2(iic_pkg::BYTE_W + 1)-1:0] bcnt_t;

    logic [1:0]                 sda_sync;
    logic                       ls_d;       // Drive point, one clock after ls
    logic                       hi_q;       // SCL high half
    logic                       active;
    bcnt_t                      bit_cnt;
    bcnt_t                      last_cnt;
    bcnt_t                      next_cnt;
    logic                       next_bit;
    logic                       start_hc;
    logic                       start_ls;
    logic                       step;
    logic [iic_pkg::BYTE_W-1:0] sh_q;
    logic [iic_pkg::BYTE_W-1:0] rd_q;

    // Periods per operation, minus one
    always_comb begin
        case (i_op.op)
            iic_pkg::OP_WRITE:     last_cnt = bcnt_t'(iic_pkg::BYTE_W - 1);
            iic_pkg::OP_READ_NACK: last_cnt = bcnt_t'(iic_pkg::BYTE_W);
            default:               last_cnt = '0;
        endcase
    end

    assign start_hc = !active && i_op.op_valid && (i_op.op == iic_pkg::OP_START) && i_ph.hc;
    assign start_ls = !active && i_op.op_valid && (i_op.op != iic_pkg::OP_START) && ls_d;
    assign step     = start_ls || (active && ls_d);
    assign next_cnt = start_ls ? '0 : bit_cnt + 1'b1;
    assign next_bit = start_ls ? i_op.wr_byte[iic_pkg::BYTE_W-1] : sh_q[iic_pkg::BYTE_W-1];

    assign i_op.op_done = active && i_ph.ls && (bit_cnt == last_cnt);
    assign i_op.rd_byte = rd_q;

    ////////////////////////////////////////
    // Control and SDA drive
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            sda_sync <= 2'b11;
            ls_d     <= 1'b0;
            hi_q     <= 1'b0;
            active   <= 1'b0;
            bit_cnt  <= '0;
            o_sda    <= 1'b1;
            o_sda_oe <= 1'b1;
        end else begin
            sda_sync <= {sda_sync[0], i_sda};
            ls_d     <= i_ph.ls;
            if (i_ph.hs) begin
                hi_q <= 1'b1;
            end else if (i_ph.ls) begin
                hi_q <= 1'b0;
            end
            if (i_op.op_done) begin
                active <= 1'b0;
            end else if (start_hc || start_ls) begin
                active <= 1'b1;
            end
            if (start_hc) begin    // START edge with SCL high
                bit_cnt  <= '0;
                o_sda_oe <= 1'b1;
                o_sda    <= 1'b0;
            end else if (step) begin
                bit_cnt <= next_cnt;
                case (i_op.op)
                    iic_pkg::OP_WRITE: begin
                        o_sda_oe <= 1'b1;
                        o_sda    <= next_bit;
                    end
                    iic_pkg::OP_READ_NACK: begin
                        o_sda_oe <= (next_cnt == bcnt_t'(iic_pkg::BYTE_W));    // NACK bit
                        o_sda    <= 1'b1;
                    end
                    iic_pkg::OP_ACK_SLOT: o_sda_oe <= 1'b0;
                    iic_pkg::OP_RESTART: begin
                        o_sda_oe <= 1'b1;
                        o_sda    <= 1'b1;
                    end
                    iic_pkg::OP_STOP: begin
                        o_sda_oe <= 1'b1;
                        o_sda    <= 1'b0;
                    end
                    default: ;
                endcase
            end else if (active && i_ph.hc) begin
                if (i_op.op == iic_pkg::OP_RESTART) begin
                    o_sda <= 1'b0;
                end else if (i_op.op == iic_pkg::OP_STOP) begin
                    o_sda <= 1'b1;
                end
            end
        end
    end

    // Data path
    always_ff @(posedge i_clk) begin
        if (start_ls) begin
            sh_q <= i_op.wr_byte << 1;
        end else if (active && ls_d) begin
            sh_q <= sh_q << 1;
        end
        if (active && i_ph.hc && (i_op.op == iic_pkg::OP_READ_NACK)
                && (bit_cnt < bcnt_t'(iic_pkg::BYTE_W))) begin
            rd_q <= {rd_q[iic_pkg::BYTE_W-2:0], sda_sync[1]};    // MSB first
        end
    end

    // SDA moves in the high half only for START, RESTART and STOP
    assert property (@(posedge i_clk) disable iff (!i_rst)
        (hi_q && o_sda_oe && $changed(o_sda)) |-> $past(i_ph.hc));

endmodule

// ==== iic_sequencer.sv ====
module iic_sequencer (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_cmd_valid,
    output logic                       o_cmd_ready,
    input  iic_pkg::iic_cmd_t          i_cmd,
    output logic                       o_rd_valid,
    input  logic                       i_rd_ready,
    output logic [iic_pkg::BYTE_W-1:0] o_rd_data,
    output logic                       o_busy,
    iic_byte_if.client                 o_op
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_SADDR_W, ST_ACK_0, ST_REG, ST_ACK_1, ST_DATA, ST_ACK_2,
        ST_RESTART, ST_SADDR_R, ST_ACK_3, ST_READ, ST_STOP, ST_RESULT
    } state_e;

    state_e            state;
    state_e            state_nxt;
    iic_pkg::iic_cmd_t cmd_q;
    logic              accept;

    assign o_cmd_ready   = (state == ST_IDLE) && i_rd_ready;    // Result stage must be empty
    assign accept        = i_cmd_valid && o_cmd_ready;
    assign o_busy        = (state != ST_IDLE) && (state != ST_RESULT);
    assign o_rd_valid    = (state == ST_RESULT);
    assign o_rd_data     = o_op.rd_byte;
    assign o_op.op_valid = o_busy;

    // Operation for each state
    always_comb begin
        o_op.op      = iic_pkg::OP_STOP;
        o_op.wr_byte = cmd_q.wdata;
        case (state)
            ST_START:   o_op.op = iic_pkg::OP_START;
            ST_RESTART: o_op.op = iic_pkg::OP_RESTART;
            ST_READ:    o_op.op = iic_pkg::OP_READ_NACK;
            ST_DATA:    o_op.op = iic_pkg::OP_WRITE;
            ST_ACK_0, ST_ACK_1, ST_ACK_2, ST_ACK_3: o_op.op = iic_pkg::OP_ACK_SLOT;
            ST_SADDR_W: begin
                o_op.op      = iic_pkg::OP_WRITE;
                o_op.wr_byte = {cmd_q.slave_addr, 1'b0};    // Write direction
            end
            ST_SADDR_R: begin
                o_op.op      = iic_pkg::OP_WRITE;
                o_op.wr_byte = {cmd_q.slave_addr, 1'b1};    // Read direction
            end
            ST_REG: begin
                o_op.op      = iic_pkg::OP_WRITE;
                o_op.wr_byte = cmd_q.reg_addr;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Transaction FSM
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (accept) state_nxt = ST_START;
            ST_RESULT: if (i_rd_ready) state_nxt = ST_IDLE;
            default: begin
                if (o_op.op_done) begin    // Advance once per bus operation
                    case (state)
                        ST_START:   state_nxt = ST_SADDR_W;
                        ST_SADDR_W: state_nxt = ST_ACK_0;
                        ST_ACK_0:   state_nxt = ST_REG;
                        ST_REG:     state_nxt = ST_ACK_1;
                        ST_ACK_1:   state_nxt = cmd_q.rd ? ST_RESTART : ST_DATA;
                        ST_DATA:    state_nxt = ST_ACK_2;
                        ST_RESTART: state_nxt = ST_SADDR_R;
                        ST_SADDR_R: state_nxt = ST_ACK_3;
                        ST_ACK_3:   state_nxt = ST_READ;
                        ST_STOP:    state_nxt = cmd_q.rd ? ST_RESULT : ST_IDLE;
                        default:    state_nxt = ST_STOP;    // After ACK_2 or READ
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_q <= i_cmd;
        end
    end

endmodule

// ==== iic_master.sv ====
module iic_master (
    input  logic                       i_clk,
    input  logic                       i_rst,
    // Command
    input  logic                       i_cmd_valid,
    output logic                       o_cmd_ready,
    input  logic                       i_cmd_read,
    input  logic [6:0]                 i_slave_addr,
    input  logic [iic_pkg::BYTE_W-1:0] i_reg_addr,
    input  logic [iic_pkg::BYTE_W-1:0] i_wdata,
    // Read result
    output logic                       o_rd_valid,
    input  logic                       i_rd_ready,
    output logic [iic_pkg::BYTE_W-1:0] o_rd_data,
    // Status and bus
    output logic                       o_busy,
    output logic                       o_scl,
    output logic                       o_sda,
    output logic                       o_sda_oe,
    input  logic                       i_sda
);

    iic_phase_if u_phase_if ();
    iic_byte_if  u_byte_if ();

    iic_pkg::iic_cmd_t          cmd_in;
    iic_pkg::iic_cmd_t          cmd_out;
    logic                       cmd_valid;
    logic                       cmd_ready;
    logic                       rd_valid;
    logic                       rd_ready;
    logic [iic_pkg::BYTE_W-1:0] rd_byte;

    assign cmd_in = {i_cmd_read, i_slave_addr, i_reg_addr, i_wdata};

    ////////////////////////////////////////
    // Command stage and sequencer
    ////////////////////////////////////////
    iic_stage_buf #(.T(iic_pkg::iic_cmd_t)) u_cmd_stage (
        .i_clk, .i_rst,
        .i_valid (i_cmd_valid), .o_ready (o_cmd_ready), .i_data (cmd_in),
        .o_valid (cmd_valid),   .i_ready (cmd_ready),   .o_data (cmd_out)
    );

    iic_sequencer u_sequencer (
        .i_clk, .i_rst,
        .i_cmd_valid (cmd_valid), .o_cmd_ready (cmd_ready), .i_cmd (cmd_out),
        .o_rd_valid  (rd_valid),  .i_rd_ready  (rd_ready),  .o_rd_data (rd_byte),
        .o_busy      (o_busy),    .o_op        (u_byte_if.client)
    );

    ////////////////////////////////////////
    // Bus side and result stage
    ////////////////////////////////////////
    iic_scl_timer u_scl_timer (.i_clk, .i_rst, .o_scl, .o_ph (u_phase_if.source));

    iic_byte_shifter u_byte_shifter (
        .i_clk, .i_rst, .i_sda, .o_sda, .o_sda_oe,
        .i_ph (u_phase_if.sink), .i_op (u_byte_if.server)
    );

    iic_stage_buf #(.T(logic [iic_pkg::BYTE_W-1:0])) u_rd_stage (
        .i_clk, .i_rst,
        .i_valid (rd_valid),   .o_ready (rd_ready),   .i_data (rd_byte),
        .o_valid (o_rd_valid), .i_ready (i_rd_ready), .o_data (o_rd_data)
    );

endmodule

// ==== tb_iic_slave_model.sv ====
module tb_iic_slave_model (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_scl,
    input  logic       i_sda,         // Master SDA level
    input  logic       i_sda_oe,      // Master SDA enable
    input  logic [6:0] i_exp_addr,    // Slave address of the current command
    output logic       o_sda,         // Wired-AND bus level
    output logic       o_in_txn,
    output logic       o_proto_err
);

    logic [7:0] mem [256];
    logic       scl_q;
    logic       sda_q;
    logic       s_drv;        // Slave SDA level, high when released
    logic       rd_mode;
    logic       restarted;
    logic [3:0] bit_cnt;      // 8 marks the ACK bit
    logic [1:0] byte_no;
    logic [7:0] shreg;
    logic [7:0] tx;
    logic [7:0] reg_ptr;
    logic       start_ev;
    logic       stop_ev;
    logic       rise;
    logic       fall;

    assign o_sda    = (i_sda_oe ? i_sda : 1'b1) & s_drv;
    assign start_ev = i_scl && scl_q && sda_q && !o_sda;
    assign stop_ev  = i_scl && scl_q && !sda_q && o_sda;
    assign rise     = i_scl && !scl_q;
    assign fall     = !i_scl && scl_q;

    initial begin
        o_proto_err = 1'b0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a) ^ 8'hA5;    // Fill pattern
        end
    end

    always @(posedge i_clk or negedge i_rst) begin
        if (!i_rst) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            s_drv     <= 1'b1;
            o_in_txn  <= 1'b0;
            rd_mode   <= 1'b0;
            restarted <= 1'b0;
            bit_cnt   <= '0;
            byte_no   <= '0;
        end else begin
            scl_q <= i_scl;
            sda_q <= o_sda;
            if (start_ev) begin
                restarted <= o_in_txn;    // START inside a transaction
                o_in_txn  <= 1'b1;
                bit_cnt   <= 4'd8;        // Next fall closes the START
                byte_no   <= '0;
                rd_mode   <= 1'b0;
                s_drv     <= 1'b1;
            end else if (stop_ev) begin
                o_in_txn <= 1'b0;
                s_drv    <= 1'b1;
            end else if (o_in_txn && rise && bit_cnt < 8) begin
                shreg <= {shreg[6:0], o_sda};
            end else if (o_in_txn && fall) begin
                if (bit_cnt == 7) begin    // Byte complete
                    bit_cnt <= 4'd8;
                    byte_no <= byte_no + 1'b1;
                    if (rd_mode) begin
                        s_drv <= 1'b1;    // Master NACKs
                    end else begin
                        s_drv <= 1'b0;
                        case (byte_no)
                            2'd0:    rd_mode <= shreg[0];
                            2'd1:    reg_ptr <= shreg;
                            default: mem[reg_ptr] <= shreg;
                        endcase
                    end
                end else if (bit_cnt == 8) begin
                    bit_cnt <= '0;
                    if (rd_mode && byte_no == 1) begin
                        tx    <= mem[reg_ptr];
                        s_drv <= mem[reg_ptr][7];
                    end else begin
                        s_drv <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (rd_mode && byte_no == 1) begin
                        s_drv <= tx[6 - bit_cnt];    // MSB first
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////
    assert property (@(posedge i_clk) disable iff (!i_rst)
        (o_in_txn && fall && bit_cnt == 7 && byte_no == 0 && !restarted)
            |-> (shreg == {i_exp_addr, 1'b0}))
    else begin
        $display("Slave model: first address byte %02h is wrong", shreg);
        o_proto_err = 1'b1;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst)
        (o_in_txn && fall && bit_cnt == 7 && byte_no == 0 && restarted)
            |-> (shreg == {i_exp_addr, 1'b1}))
    else begin
        $display("Slave model: address after repeated START %02h is wrong", shreg);
        o_proto_err = 1'b1;
    end

    // Repeated START only after the register byte
    assert property (@(posedge i_clk) disable iff (!i_rst)
        (start_ev && o_in_txn) |-> (byte_no == 2 && bit_cnt == 0))
    else begin
        $display("Slave model: repeated START at the wrong point");
        o_proto_err = 1'b1;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst)
        stop_ev |-> (o_in_txn && bit_cnt == 0))
    else begin
        $display("Slave model: STOP without a started transaction or inside a byte");
        o_proto_err = 1'b1;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst)
        (i_scl && scl_q && (o_sda != sda_q)) |-> (!o_in_txn || bit_cnt == 0))
    else begin
        $display("Slave model: SDA changed while SCL was high inside a byte");
        o_proto_err = 1'b1;
    end

endmodule

// ==== tb_iic_master.sv ====
module tb_iic_master;

    localparam int LFSR_SEED   = 10605;
    localparam int TIMEOUT_CYC = 100000;    // Well above one read transaction

    logic       i_clk;
    logic       i_rst;
    logic       i_cmd_valid;
    logic       i_cmd_read;
    logic [6:0] i_slave_addr;
    logic [7:0] i_reg_addr;
    logic [7:0] i_wdata;
    logic       i_rd_ready;
    logic       i_sda;
    logic       o_cmd_ready;
    logic       o_rd_valid;
    logic [7:0] o_rd_data;
    logic       o_busy;
    logic       o_scl;
    logic       o_sda;
    logic       o_sda_oe;
    logic [6:0] exp_addr;
    logic       in_txn;
    logic       proto_err;
    logic [15:0] lfsr;
    logic [7:0] used_regs [$];

    iic_master uut (.*);

    tb_iic_slave_model u_slave (
        .i_clk, .i_rst, .i_scl (o_scl), .i_sda (o_sda), .i_sda_oe (o_sda_oe),
        .i_exp_addr (exp_addr), .o_sda (i_sda), .o_in_txn (in_txn), .o_proto_err (proto_err)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_step()};
        end
    endtask

    function automatic logic is_used(input logic [7:0] r);
        foreach (used_regs[i]) begin
            if (used_regs[i] == r) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic send_cmd(input logic rd, input logic [6:0] a, input logic [7:0] r,
                            input logic [7:0] d);
        int n;
        @(posedge i_clk);
        #2;
        i_cmd_read   = rd;
        i_slave_addr = a;
        i_reg_addr   = r;
        i_wdata      = d;
        exp_addr     = a;
        i_cmd_valid  = 1'b1;
        n = 0;
        while (!o_cmd_ready) begin
            @(posedge i_clk);
            #2;
            n++;
            if (n > TIMEOUT_CYC) fail_run("Timeout waiting for o_cmd_ready");
        end
        @(posedge i_clk);    // Transfer edge
        #2;
        i_cmd_valid = 1'b0;
    endtask

    task automatic wait_transaction();
        int n;
        n = 0;
        while (!o_busy) begin
            @(posedge i_clk);
            #2;
            n++;
            if (n > TIMEOUT_CYC) fail_run("Timeout waiting for o_busy to rise");
        end
        n = 0;
        while (o_busy) begin
            @(posedge i_clk);
            #2;
            n++;
            if (n > TIMEOUT_CYC) fail_run("Timeout waiting for o_busy to fall");
        end
    endtask

    task automatic check_result(input string name, input logic [7:0] exp);
        int         n;
        logic [7:0] stall;
        n = 0;
        while (!o_rd_valid) begin
            @(posedge i_clk);
            #2;
            n++;
            if (n > TIMEOUT_CYC) fail_run("Timeout waiting for o_rd_valid");
        end
        assert (o_rd_data == exp)
        else fail_run($sformatf("Error: %s expected %02h actual %02h", name, exp, o_rd_data));
        take_bits(3, stall);    // Short random stall before taking
        i_rd_ready = 1'b0;
        repeat (stall) @(posedge i_clk);
        #2;
        i_rd_ready = 1'b1;
        @(posedge i_clk);
        #2;
    endtask

    always @(posedge i_clk) begin
        if (proto_err) fail_run("The slave model saw a bus protocol violation");
    end

    // Busy framing
    assert property (@(posedge i_clk) disable iff (!i_rst) in_txn |-> o_busy)
    else fail_run("o_busy was low during a bus transaction");

    assert property (@(posedge i_clk) disable iff (!i_rst) $fell(in_txn) |-> ##[1:400] !o_busy)
    else fail_run("o_busy stayed high after STOP");

    initial begin
        logic [7:0] a;
        logic [7:0] r;
        logic [7:0] d;
        logic [7:0] held;
        logic [7:0] stall;
        int         n;
        i_rst        = 1'b0;
        i_cmd_valid  = 1'b0;
        i_cmd_read   = 1'b0;
        i_slave_addr = '0;
        i_reg_addr   = '0;
        i_wdata      = '0;
        i_rd_ready   = 1'b1;
        exp_addr     = '0;
        lfsr         = 16'(LFSR_SEED);
        repeat (3) @(posedge i_clk);
        #2;
        i_rst = 1'b1;
        @(posedge i_clk);
        #2;
        assert (o_scl && o_sda && o_sda_oe && o_cmd_ready && !o_busy && !o_rd_valid)
        else fail_run("Outputs are not in their reset state");

        ////////////////////////////////////////
        // Write then read back
        ////////////////////////////////////////
        for (int k = 0; k < 3; k++) begin
            take_bits(7, a);
            take_bits(8, r);
            take_bits(8, d);
            used_regs.push_back(r);
            send_cmd(1'b0, a[6:0], r, d);
            wait_transaction();
            send_cmd(1'b1, a[6:0], r, 8'h00);
            wait_transaction();
            check_result("write_read_back", d);
        end

        // Register never written
        take_bits(8, r);
        while (is_used(r)) take_bits(8, r);
        send_cmd(1'b1, a[6:0], r, 8'h00);
        wait_transaction();
        check_result("untouched_reg", r ^ 8'hA5);

        ////////////////////////////////////////
        // Result back-pressure
        ////////////////////////////////////////
        i_rd_ready = 1'b0;
        send_cmd(1'b1, a[6:0], r, 8'h00);
        wait_transaction();
        n = 0;
        while (!o_rd_valid) begin
            @(posedge i_clk);
            #2;
            n++;
            if (n > TIMEOUT_CYC) fail_run("Timeout waiting for the held read result");
        end
        held = o_rd_data;
        assert (held == (r ^ 8'hA5))
        else fail_run($sformatf("Error: stalled_read expected %02h actual %02h",
                                r ^ 8'hA5, held));
        send_cmd(1'b0, a[6:0], used_regs[0], 8'h3C);
        take_bits(5, stall);
        repeat (int'(stall) + 20) begin
            assert (o_rd_valid && o_rd_data == held && !o_busy && !o_cmd_ready)
            else fail_run("Held result changed or a command started during back-pressure");
            @(posedge i_clk);
            #2;
        end
        i_rd_ready = 1'b1;
        wait_transaction();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
iic_pkg.sv
iic_phase_if.sv
iic_byte_if.sv
iic_stage_buf.sv
iic_scl_timer.sv
iic_byte_shifter.sv
iic_sequencer.sv
iic_master.sv
tb_iic_slave_model.sv
tb_iic_master.sv

// ==== Bender.yml ====
package:
  name: iic_master

sources:
  - iic_pkg.sv
  - iic_phase_if.sv
  - iic_byte_if.sv
  - iic_stage_buf.sv
  - iic_scl_timer.sv
  - iic_byte_shifter.sv
  - iic_sequencer.sv
  - iic_master.sv
  - target: test
    files:
      - tb_iic_slave_model.sv
      - tb_iic_master.sv
